/* sim.f */
+incdir+src
src/exec_pkg.sv
src/register_file.sv
src/instr_decoder.sv
src/alu.sv
src/exec_core.sv
testbench/exec_checker.sv
testbench/tb_exec_core.sv

/* testbench/tb_exec_core.sv */
// Execute pipeline testbench
// Drives a table of instructions into the DUT, the checker compares outputs

`timescale 1ns/1ps

module tb_exec_core import exec_pkg::*; ();

    localparam int   DRIVE_DELAY = 2;
    localparam int   DRAIN_LIMIT = 20;
    localparam logic WORD = 1'b0;
    localparam logic BYTE = 1'b1;

    logic   clk;
    logic   rst_n;
    logic   instr_valid;
    word_t  instr;
    word_t  imm;
    logic   done;
    word_t  result;
    flags_t flags;

    // Expectation handed to the checker with each instruction
    logic   exp_push;
    int     exp_row;
    word_t  exp_result;
    flags_t exp_flags;

    logic   idle;
    int     result_errors;
    int     flags_errors;
    int     sequence_errors;
    int     drain_errors;

    // Stimulus table, one entry per instruction
    word_t  row_instr [$];
    word_t  row_imm [$];
    word_t  row_result [$];
    flags_t row_flags [$];
    int     row_gap [$];

    exec_core exec_core_inst (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .imm(imm),
        .done(done), .result(result), .flags(flags)
    );

    exec_checker exec_checker_inst (
        .clk(clk), .rst_n(rst_n), .exp_push(exp_push), .exp_row(exp_row),
        .exp_result(exp_result), .exp_flags(exp_flags),
        .done(done), .result(result), .flags(flags), .idle(idle),
        .result_errors(result_errors), .flags_errors(flags_errors),
        .sequence_errors(sequence_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // op 15:13, byte 12, dst 11:9, src 8:6
    function automatic word_t encode_instr(alu_op_e op, logic byte_mode,
                                           reg_sel_t dst, reg_sel_t src);
        return {op, byte_mode, dst, src, 6'b000000};
    endfunction

    // gap is the number of idle cycles after the row
    task automatic add_row(alu_op_e op, logic byte_mode, reg_sel_t dst, reg_sel_t src,
                           word_t imm_val, word_t exp_res, flags_t exp_fl, int gap);
        row_instr.push_back(encode_instr(op, byte_mode, dst, src));
        row_imm.push_back(imm_val);
        row_result.push_back(exp_res);
        row_flags.push_back(exp_fl);
        row_gap.push_back(gap);
    endtask

    // Selects 0..3 AX CX DX BX (AL..BL), 4..7 SP BP SI DI (AH..BH)
    // Flags column is {sf, zf, cf} after the row
    task automatic build_table();
        word_t r0;
        word_t r1;
        word_t r2;
        r0 = word_t'($urandom());
        r1 = word_t'($urandom());
        r2 = word_t'($urandom());
        // Load every register, then copies with idle gaps
        add_row(OP_MOVI, WORD, 3'd0, 3'd0, 16'h1234, 16'h1234, 3'b000, 0);
        add_row(OP_MOVI, WORD, 3'd1, 3'd0, 16'hA5C3, 16'hA5C3, 3'b000, 0);
        add_row(OP_MOVI, WORD, 3'd2, 3'd0, 16'h0F0F, 16'h0F0F, 3'b000, 0);
        add_row(OP_MOVI, WORD, 3'd3, 3'd0, 16'h8001, 16'h8001, 3'b000, 0);
        add_row(OP_MOVI, WORD, 3'd4, 3'd0, 16'h7FFF, 16'h7FFF, 3'b000, 0);
        add_row(OP_MOVI, WORD, 3'd5, 3'd0, 16'h0001, 16'h0001, 3'b000, 0);
        add_row(OP_MOVI, WORD, 3'd6, 3'd0, 16'hFFFF, 16'hFFFF, 3'b000, 0);
        add_row(OP_MOVI, WORD, 3'd7, 3'd0, 16'h4C21, 16'h4C21, 3'b000, 1);
        add_row(OP_MOV,  WORD, 3'd6, 3'd1, 16'h0000, 16'hA5C3, 3'b000, 2);
        add_row(OP_MOV,  WORD, 3'd7, 3'd3, 16'h0000, 16'h8001, 3'b000, 1);
        add_row(OP_MOV,  WORD, 3'd5, 3'd0, 16'h0000, 16'h1234, 3'b000, 3);
        // AL then AH, upper immediate byte ignored, AX reads C75A
        add_row(OP_MOVI, BYTE, 3'd0, 3'd0, 16'h3C5A, 16'h005A, 3'b000, 1);
        add_row(OP_MOVI, BYTE, 3'd4, 3'd0, 16'h11C7, 16'h00C7, 3'b000, 1);
        add_row(OP_MOV,  WORD, 3'd2, 3'd0, 16'h0000, 16'hC75A, 3'b000, 1);
        // Word arithmetic, sign, carry, zero and borrow
        add_row(OP_ADD,  WORD, 3'd4, 3'd5, 16'h0000, 16'h9233, 3'b100, 0);
        add_row(OP_ADD,  WORD, 3'd6, 3'd1, 16'h0000, 16'h4B86, 3'b001, 0);
        add_row(OP_MOVI, WORD, 3'd5, 3'd0, 16'hFFFF, 16'hFFFF, 3'b001, 0);
        add_row(OP_MOVI, WORD, 3'd7, 3'd0, 16'h0001, 16'h0001, 3'b001, 0);
        add_row(OP_ADD,  WORD, 3'd5, 3'd7, 16'h0000, 16'h0000, 3'b011, 0);
        add_row(OP_SUB,  WORD, 3'd7, 3'd4, 16'h0000, 16'h6DCE, 3'b001, 0);
        add_row(OP_SUB,  WORD, 3'd4, 3'd2, 16'h0000, 16'hCAD9, 3'b101, 0);
        // CMP shows the difference, AX stays C75A
        add_row(OP_CMP,  WORD, 3'd0, 3'd2, 16'h0000, 16'h0000, 3'b010, 0);
        add_row(OP_MOV,  WORD, 3'd1, 3'd0, 16'h0000, 16'hC75A, 3'b010, 1);
        add_row(OP_CMP,  WORD, 3'd3, 3'd6, 16'h0000, 16'h347B, 3'b000, 1);
        add_row(OP_MOV,  WORD, 3'd2, 3'd3, 16'h0000, 16'h8001, 3'b000, 1);
        add_row(OP_SUB,  WORD, 3'd1, 3'd0, 16'h0000, 16'h0000, 3'b010, 1);
        // Byte arithmetic, carry out of bit 7
        add_row(OP_ADD,  BYTE, 3'd0, 3'd4, 16'h0000, 16'h0021, 3'b001, 1);
        add_row(OP_ADD,  BYTE, 3'd2, 3'd7, 16'h0000, 16'h0081, 3'b100, 0);
        add_row(OP_SUB,  BYTE, 3'd1, 3'd2, 16'h0000, 16'h007F, 3'b001, 0);
        add_row(OP_SUB,  BYTE, 3'd4, 3'd4, 16'h0000, 16'h0000, 3'b010, 1);
        add_row(OP_ADD,  BYTE, 3'd7, 3'd6, 16'h0000, 16'h0000, 3'b011, 1);
        // Logic ops clear cf in both widths
        add_row(OP_AND,  WORD, 3'd6, 3'd7, 16'h0000, 16'h4986, 3'b000, 0);
        add_row(OP_OR,   WORD, 3'd5, 3'd4, 16'h0000, 16'hCAD9, 3'b100, 0);
        add_row(OP_XOR,  WORD, 3'd5, 3'd4, 16'h0000, 16'h0000, 3'b010, 1);
        add_row(OP_ADD,  BYTE, 3'd6, 3'd6, 16'h0000, 16'h0000, 3'b011, 0);
        add_row(OP_AND,  BYTE, 3'd1, 3'd0, 16'h0000, 16'h0021, 3'b000, 0);
        add_row(OP_OR,   BYTE, 3'd4, 3'd2, 16'h0000, 16'h0081, 3'b100, 0);
        add_row(OP_XOR,  BYTE, 3'd3, 3'd3, 16'h0000, 16'h0000, 3'b010, 1);
        // Bypass merges, byte write then word read, word write then high byte read
        add_row(OP_MOVI, BYTE, 3'd5, 3'd0, 16'h77E4, 16'h00E4, 3'b010, 0);
        add_row(OP_MOV,  WORD, 3'd2, 3'd1, 16'h0000, 16'hE421, 3'b010, 0);
        add_row(OP_MOVI, WORD, 3'd3, 3'd0, 16'h9C3B, 16'h9C3B, 3'b010, 0);
        add_row(OP_MOV,  BYTE, 3'd1, 3'd7, 16'h0000, 16'h009C, 3'b010, 0);
        add_row(OP_ADD,  WORD, 3'd2, 3'd1, 16'h0000, 16'hC8BD, 3'b101, 1);
        // Random fillers
        add_row(OP_MOVI, WORD, 3'd7, 3'd0, r0, r0, 3'b101, 0);
        add_row(OP_MOVI, WORD, 3'd7, 3'd0, r1, r1, 3'b101, 0);
        add_row(OP_MOV,  WORD, 3'd6, 3'd7, 16'h0000, r1, 3'b101, 1);
        add_row(OP_MOVI, BYTE, 3'd7, 3'd0, r2, {8'h00, r2[7:0]}, 3'b101, 0);
        add_row(OP_MOV,  WORD, 3'd0, 3'd3, 16'h0000, {r2[7:0], 8'h3B}, 3'b101, 2);
    endtask

    initial begin
        int unsigned seed;
        int          drain_cycles;
        seed = 32'h6a56_8321;
        void'($urandom(seed));
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        imm          = '0;
        exp_push     = 1'b0;
        exp_row      = 0;
        exp_result   = '0;
        exp_flags    = '0;
        drain_errors = 0;
        build_table();

        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (int i = 0; i < row_instr.size(); i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            instr_valid = 1'b1;
            instr       = row_instr[i];
            imm         = row_imm[i];
            exp_push    = 1'b1;
            exp_row     = i;
            exp_result  = row_result[i];
            exp_flags   = row_flags[i];
            for (int g = 0; g < row_gap[i]; g++) begin
                @(posedge clk);
                #DRIVE_DELAY;
                instr_valid = 1'b0;
                exp_push    = 1'b0;
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b0;
        exp_push    = 1'b0;

        // Let the last results and flags reach the checker
        drain_cycles = 0;
        while (!idle && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            drain_cycles++;
        end
        if (!idle) begin
            $display("Checker still had outstanding instructions after %0d cycles",
                     DRAIN_LIMIT);
            drain_errors++;
        end

        $display("Errors: result %0d, flags %0d, sequence %0d, drain %0d",
                 result_errors, flags_errors, sequence_errors, drain_errors);
        if (result_errors + flags_errors + sequence_errors + drain_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* testbench/exec_checker.sv */
// Execute pipeline checker
// Queues one expectation per accepted instruction, compares result on done
// and the registered flags one cycle later

`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // Expectation for the instruction accepted this cycle
    input  logic   exp_push,
    input  int     exp_row,
    input  word_t  exp_result,
    input  flags_t exp_flags,
    // DUT outputs
    input  logic   done,
    input  word_t  result,
    input  flags_t flags,
    // Status for the testbench
    output logic   idle,
    output int     result_errors,
    output int     flags_errors,
    output int     sequence_errors
);

    // Cycles allowed between accept and done
    localparam int DONE_TIMEOUT = 5;

    int     row_q [$];
    word_t  result_q [$];
    flags_t flags_q [$];
    // Accept cycle of each outstanding row
    int     accept_q [$];

    // Flags of the last finished instruction, due one cycle after done
    logic   flags_pending;
    flags_t flags_due;
    int     flags_row;
    int     wait_cycles;
    // Falling edges since reset, done is due one edge after the accept
    int     cycle_count;
    int     accept_cycle;

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            row_q.delete();
            result_q.delete();
            flags_q.delete();
            accept_q.delete();
            flags_pending   = 1'b0;
            wait_cycles     = 0;
            cycle_count     = 0;
            result_errors   = 0;
            flags_errors    = 0;
            sequence_errors = 0;
        end else begin
            cycle_count++;
            if (flags_pending) begin
                if (flags !== flags_due) begin
                    $display("Fail %0t: row %0d flags %b, expected %b",
                             $time, flags_row, flags, flags_due);
                    flags_errors++;
                end
                flags_pending = 1'b0;
            end
            if (done === 1'b1) begin
                wait_cycles = 0;
                if (row_q.size() == 0) begin
                    $display("Done pulse at %0t with no instruction outstanding", $time);
                    sequence_errors++;
                end else begin
                    flags_row    = row_q.pop_front();
                    flags_due    = flags_q.pop_front();
                    accept_cycle = accept_q.pop_front();
                    if (cycle_count != accept_cycle + 1) begin
                        $display("Done for row %0d came %0d cycles after accept at %0t",
                                 flags_row, cycle_count - accept_cycle, $time);
                        sequence_errors++;
                    end
                    if (result !== result_q[0]) begin
                        $display("Fail %0t: row %0d result 0x%04h, expected 0x%04h",
                                 $time, flags_row, result, result_q[0]);
                        result_errors++;
                    end
                    result_q.delete(0);
                    flags_pending = 1'b1;
                end
            end else if (row_q.size() != 0) begin
                wait_cycles++;
                // Drop the stuck entry so later rows still line up
                if (wait_cycles >= DONE_TIMEOUT) begin
                    $display("Timeout: no done within %0d cycles for row %0d",
                             DONE_TIMEOUT, row_q[0]);
                    row_q.delete(0);
                    result_q.delete(0);
                    flags_q.delete(0);
                    accept_q.delete(0);
                    sequence_errors++;
                    wait_cycles = 0;
                end
            end
            if (exp_push === 1'b1) begin
                row_q.push_back(exp_row);
                result_q.push_back(exp_result);
                flags_q.push_back(exp_flags);
                accept_q.push_back(cycle_count);
            end
        end
        idle = (row_q.size() == 0) && !flags_pending;
    end

endmodule

/* src/exec_core.sv */
// Execute pipeline top level
// Decode and operand read in stage 1, ALU and write-back in stage 2

`timescale 1ns/1ps

module exec_core import exec_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   instr_valid,
    input  word_t  instr,
    input  word_t  imm,
    output logic   done,
    output word_t  result,
    output flags_t flags
);

    // Stage 1 read selects
    reg_sel_t rd_sel0;
    reg_sel_t rd_sel1;
    logic     rd_byte;

    // Stage 2 fields and operands
    logic     ex_valid;
    alu_op_e  ex_op;
    logic     ex_byte;
    reg_sel_t ex_dst;
    word_t    ex_imm;
    word_t    a_val;
    word_t    b_val;

    // Write-back path
    logic     wr_en;
    reg_sel_t wr_sel;
    logic     wr_byte;
    word_t    wr_val;

    instr_decoder instr_decoder_inst (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .imm(imm),
        .rd_sel0(rd_sel0), .rd_sel1(rd_sel1), .rd_byte(rd_byte),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_byte(ex_byte), .ex_dst(ex_dst),
        .ex_imm(ex_imm)
    );

    register_file register_file_inst (
        .clk(clk), .rd_sel0(rd_sel0), .rd_sel1(rd_sel1), .rd_byte(rd_byte),
        .rd_val0(a_val), .rd_val1(b_val),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_byte(wr_byte), .wr_val(wr_val)
    );

    alu alu_inst (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_op(ex_op), .ex_byte(ex_byte),
        .ex_dst(ex_dst), .ex_imm(ex_imm), .a_val(a_val), .b_val(b_val),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_byte(wr_byte), .wr_val(wr_val),
        .done(done), .result(result), .flags(flags)
    );

endmodule

/* src/alu.sv */
// Execute stage ALU
// 8- or 16-bit arithmetic and logic with carry and borrow
// Drives the register write-back and holds the flags register

`timescale 1ns/1ps

`include "exec_params.svh"

module alu import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ex_valid,
    input  alu_op_e  ex_op,
    input  logic     ex_byte,
    input  reg_sel_t ex_dst,
    input  word_t    ex_imm,
    // Operands, already zero-extended in byte mode
    input  word_t    a_val,
    input  word_t    b_val,
    // Write-back to the register file
    output logic     wr_en,
    output reg_sel_t wr_sel,
    output logic     wr_byte,
    output word_t    wr_val,
    output logic     done,
    output word_t    result,
    output flags_t   flags
);

    // One spare bit above the word catches carry and borrow
    logic [`EXEC_DATA_W:0] arith;
    word_t                 alu_out;
    word_t                 res;
    logic                  carry;
    logic                  flags_upd;
    flags_t                flags_next;

    always_comb begin
        // SUB and CMP share the subtractor
        if (ex_op == OP_ADD) begin
            arith = {1'b0, a_val} + {1'b0, b_val};
        end else begin
            arith = {1'b0, a_val} - {1'b0, b_val};
        end
        // Zero-extended byte operands put carry or borrow in bit 8
        carry = ex_byte ? arith[8] : arith[`EXEC_DATA_W];

        unique case (ex_op)
            OP_MOVI: alu_out = ex_imm;
            OP_MOV:  alu_out = b_val;
            OP_AND:  alu_out = a_val & b_val;
            OP_OR:   alu_out = a_val | b_val;
            OP_XOR:  alu_out = a_val ^ b_val;
            default: alu_out = arith[`EXEC_DATA_W-1:0];
        endcase
        res = ex_byte ? {8'h00, alu_out[7:0]} : alu_out;

        // MOV and MOVI keep the flags
        flags_upd  = (ex_op != OP_MOVI) && (ex_op != OP_MOV);
        // Logic ops clear carry
        flags_next[FLAG_CF] = (ex_op == OP_ADD || ex_op == OP_SUB || ex_op == OP_CMP) ?
                              carry : 1'b0;
        flags_next[FLAG_ZF] = ex_byte ? (res[7:0] == 8'h00) : (res == '0);
        flags_next[FLAG_SF] = ex_byte ? res[7] : res[15];
    end

    // CMP only sets flags
    assign wr_en   = ex_valid && (ex_op != OP_CMP);
    assign wr_sel  = ex_dst;
    assign wr_byte = ex_byte;
    assign wr_val  = res;
    assign done    = ex_valid;
    assign result  = res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ex_valid && flags_upd) begin
            flags <= flags_next;
        end
    end

endmodule

/* src/instr_decoder.sv */
// Instruction decoder, first pipeline stage
// Drives the operand read selects in the accept cycle and
// registers the fields the execute stage needs

`timescale 1ns/1ps

module instr_decoder import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  word_t    instr,
    input  word_t    imm,
    // Register file read selects, combinational
    output reg_sel_t rd_sel0,
    output reg_sel_t rd_sel1,
    output logic     rd_byte,
    // Registered fields for the execute stage
    output logic     ex_valid,
    output alu_op_e  ex_op,
    output logic     ex_byte,
    output reg_sel_t ex_dst,
    output word_t    ex_imm
);

    // Instruction fields, bits 5:0 are spare
    alu_op_e  dec_op;
    logic     dec_byte;
    reg_sel_t dec_dst;
    reg_sel_t dec_src;

    always_comb begin
        dec_op   = alu_op_e'(instr[15:13]);
        dec_byte = instr[12];
        dec_dst  = instr[11:9];
        dec_src  = instr[8:6];
    end

    // Port 0 reads the destination, port 1 the source
    assign rd_sel0 = dec_dst;
    assign rd_sel1 = dec_src;
    assign rd_byte = dec_byte;

    // Stage 2 valid bit, low on idle cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= instr_valid;
        end
    end

    // Payload only moves with a new instruction
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_op   <= dec_op;
            ex_byte <= dec_byte;
            ex_dst  <= dec_dst;
            ex_imm  <= imm;
        end
    end

endmodule

/* src/register_file.sv */
// General-purpose register file
// Eight words, two registered read ports and one write port
// Byte access to AL..BL and AH..BH with a width-merging write bypass

`timescale 1ns/1ps

`include "exec_params.svh"

module register_file import exec_pkg::*; (
    input  logic     clk,
    // Read ports, sampled at the end of the accept cycle
    input  reg_sel_t rd_sel0,
    input  reg_sel_t rd_sel1,
    input  logic     rd_byte,
    output word_t    rd_val0,
    output word_t    rd_val1,
    // Write port from the second stage
    input  logic     wr_en,
    input  reg_sel_t wr_sel,
    input  logic     wr_byte,
    input  word_t    wr_val
);

    // Register storage, contents not reset
    word_t gprs [`EXEC_NUM_REGS];

    // Write side decode
    reg_sel_t   wr_phys;
    logic [1:0] wr_lanes;
    word_t      wr_data;

    // Read side decode and next values
    reg_sel_t rd_phys0;
    reg_sel_t rd_phys1;
    word_t    rd_next0;
    word_t    rd_next1;

    // In byte mode bit 2 picks the half and bits 1:0 pick AX..BX
    function automatic reg_sel_t phys_reg(reg_sel_t sel, logic byte_mode);
        return byte_mode ? {1'b0, sel[1:0]} : sel;
    endfunction

    // Overlay the written bytes, then cut down to the read width
    function automatic word_t read_path(word_t stored, reg_sel_t sel, logic byte_mode,
                                        logic hit, word_t wdata, logic [1:0] lanes);
        word_t merged;
        merged[15:8] = (hit && lanes[1]) ? wdata[15:8] : stored[15:8];
        merged[7:0]  = (hit && lanes[0]) ? wdata[7:0] : stored[7:0];
        if (byte_mode) begin
            return {8'h00, sel[2] ? merged[15:8] : merged[7:0]};
        end
        return merged;
    endfunction

    always_comb begin
        wr_phys = phys_reg(wr_sel, wr_byte);
        // Byte value copied to both halves, lanes pick which one lands
        wr_data  = wr_byte ? {wr_val[7:0], wr_val[7:0]} : wr_val;
        wr_lanes = wr_byte ? (wr_sel[2] ? 2'b10 : 2'b01) : 2'b11;
    end

    always_comb begin
        rd_phys0 = phys_reg(rd_sel0, rd_byte);
        rd_phys1 = phys_reg(rd_sel1, rd_byte);
        // Bypass hits on the physical register, not on the select
        rd_next0 = read_path(gprs[rd_phys0], rd_sel0, rd_byte,
                             wr_en && (wr_phys == rd_phys0), wr_data, wr_lanes);
        rd_next1 = read_path(gprs[rd_phys1], rd_sel1, rd_byte,
                             wr_en && (wr_phys == rd_phys1), wr_data, wr_lanes);
    end

    always_ff @(posedge clk) begin
        rd_val0 <= rd_next0;
        rd_val1 <= rd_next1;
    end

    // Only the touched halves are written
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_lanes[1]) begin
                gprs[wr_phys][15:8] <= wr_data[15:8];
            end
            if (wr_lanes[0]) begin
                gprs[wr_phys][7:0] <= wr_data[7:0];
            end
        end
    end

endmodule

/* src/exec_pkg.sv */
// Execute pipeline types
// Data word, register select, flags vector and ALU opcode encoding

`include "exec_params.svh"

package exec_pkg;

    // One data word
    typedef logic [`EXEC_DATA_W-1:0] word_t;

    // Register select, also used as a byte select in byte mode
    typedef logic [$clog2(`EXEC_NUM_REGS)-1:0] reg_sel_t;

    // Status flags
    typedef logic [2:0] flags_t;

    // Bit positions inside flags_t
    localparam int FLAG_CF = 0;
    localparam int FLAG_ZF = 1;
    localparam int FLAG_SF = 2;

    // Opcode encoding, instruction bits 15:13
    typedef enum logic [`EXEC_OP_W-1:0] {
        OP_MOVI = 3'd0,
        OP_MOV  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_AND  = 3'd4,
        OP_OR   = 3'd5,
        OP_XOR  = 3'd6,
        OP_CMP  = 3'd7
    } alu_op_e;

endpackage

/* src/exec_params.svh */
// Execute pipeline parameters
// Sizes shared by the register file, the ALU and the type package

`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// General-purpose registers AX CX DX BX SP BP SI DI
`define EXEC_NUM_REGS 8

// Datapath width, one 8086 word
`define EXEC_DATA_W 16

// Opcode field at the top of the instruction word
`define EXEC_OP_W 3

`endif
